// ==== all.f ====
rtl/panel_ctrl_pkg.sv
rtl/cmd_dispatch.sv
rtl/cmd_blankpanel.sv
rtl/cmd_readpixel.sv
rtl/panel_ctrl_top.sv
tb/panel_ctrl_checker.sv
tb/panel_ctrl_monitor.sv
tb/panel_ctrl_tb.sv

// ==== rtl/cmd_blankpanel.sv ====
// blank engine: sweeps every frame RAM byte address, one write per cycle
`timescale 1ns/1ps
`default_nettype none

module cmd_blankpanel (
    input  logic                               clk_in,
    input  logic                               reset,
    input  panel_ctrl_pkg::ctrl_state_e        cmd_state,
    output logic [panel_ctrl_pkg::ADDR_BITS-1:0] blank_address,
    output logic                               blank_write_enable,
    output logic                               blank_done
);
    import panel_ctrl_pkg::*;

    logic active;

    assign active = (cmd_state == STATE_BLANK_PANEL);

    // address counter doubles as the output
    always_ff @(posedge clk_in) begin
        if (reset) begin
            blank_address <= '0;
        end else if (active) begin
            blank_address <= blank_address + 1'b1;
        end else begin
            blank_address <= '0;
        end
    end

    assign blank_write_enable = active;

    // last address written this cycle
    assign blank_done = active && (blank_address == ADDR_BITS'(RAM_DEPTH - 1));

endmodule

`default_nettype wire

// ==== rtl/cmd_dispatch.sv ====
// command dispatcher: idle byte decoder, command state register,
// rgb and brightness enable registers
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
    input  logic                                       clk_in,
    input  logic                                       reset,
    input  logic [7:0]                                 data_rx,
    input  logic                                       data_ready_n,
    input  logic                                       blank_done,
    input  logic                                       pixel_done,
    output panel_ctrl_pkg::ctrl_state_e                cmd_state,
    output logic [2:0]                                 rgb_enable,
    output logic [panel_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic                                       busy,
    output logic                                       ready_for_data
);
    import panel_ctrl_pkg::*;

    logic        accept;
    cmd_opcode_e opcode;
    logic        is_toggle;
    logic [2:0]  toggle_bit;

    // blank engine owns every cycle, so hold off the sender
    assign ready_for_data = (cmd_state != STATE_BLANK_PANEL);
    assign busy = (cmd_state != STATE_IDLE);
    assign accept = ~data_ready_n & ready_for_data;

    assign opcode = cmd_opcode_e'(data_rx);

    // digit n toggles bit 6-n
    assign is_toggle = (data_rx >= 8'h31) && (data_rx <= 8'h36);
    assign toggle_bit = 3'(BRIGHTNESS_LEVELS) - data_rx[2:0];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            cmd_state <= STATE_IDLE;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            case (cmd_state)
                STATE_IDLE: begin
                    if (accept) begin
                        case (opcode)
                            OP_RED_ON: begin
                                rgb_enable[0] <= 1'b1;
                            end
                            OP_RED_OFF: begin
                                rgb_enable[0] <= 1'b0;
                            end
                            OP_GREEN_ON: begin
                                rgb_enable[1] <= 1'b1;
                            end
                            OP_GREEN_OFF: begin
                                rgb_enable[1] <= 1'b0;
                            end
                            OP_BLUE_ON: begin
                                rgb_enable[2] <= 1'b1;
                            end
                            OP_BLUE_OFF: begin
                                rgb_enable[2] <= 1'b0;
                            end
                            OP_BRIGHT_ALL_OFF: begin
                                brightness_enable <= '0;
                            end
                            OP_BRIGHT_ALL_ON: begin
                                brightness_enable <= '1;
                            end
                            OP_READ_BRIGHTNESS: begin
                                cmd_state <= STATE_READ_BRIGHTNESS;
                            end
                            OP_BLANK_PANEL: begin
                                cmd_state <= STATE_BLANK_PANEL;
                            end
                            OP_READ_PIXEL: begin
                                cmd_state <= STATE_READ_PIXEL;
                            end
                            default: begin
                                // anything else that is not a digit is dropped
                                if (is_toggle) begin
                                    brightness_enable[toggle_bit] <=
                                        ~brightness_enable[toggle_bit];
                                end
                            end
                        endcase
                    end
                end
                STATE_READ_BRIGHTNESS: begin
                    if (accept) begin
                        brightness_enable <= data_rx[BRIGHTNESS_LEVELS-1:0];
                        cmd_state <= STATE_IDLE;
                    end
                end
                STATE_BLANK_PANEL: begin
                    if (blank_done) begin
                        cmd_state <= STATE_IDLE;
                    end
                end
                STATE_READ_PIXEL: begin
                    if (pixel_done) begin
                        cmd_state <= STATE_IDLE;
                    end
                end
                default: begin
                    cmd_state <= STATE_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cmd_readpixel.sv ====
// pixel engine: takes row, column and two colour bytes,
// writes the colour bytes to the frame RAM
`timescale 1ns/1ps
`default_nettype none

module cmd_readpixel (
    input  logic                               clk_in,
    input  logic                               reset,
    input  panel_ctrl_pkg::ctrl_state_e        cmd_state,
    input  logic [7:0]                         data_rx,
    input  logic                               data_ready_n,
    output logic [panel_ctrl_pkg::ADDR_BITS-1:0] pixel_address,
    output logic [7:0]                         pixel_data,
    output logic                               pixel_write_enable,
    output logic                               pixel_done
);
    import panel_ctrl_pkg::*;

    logic                   accept;
    logic [1:0]             byte_pos;
    logic [ROW_BITS-1:0]    row;
    logic [COL_BITS-1:0]    col;
    logic [PIXSEL_BITS-1:0] pixsel;

    assign accept = (cmd_state == STATE_READ_PIXEL) && ~data_ready_n;

    // 0 row, 1 column, 2 and 3 colour bytes
    always_ff @(posedge clk_in) begin
        if (reset || pixel_done) begin
            byte_pos <= '0;
        end else if (accept) begin
            byte_pos <= byte_pos + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixel_write_enable <= 1'b0;
            pixel_done <= 1'b0;
        end else begin
            pixel_write_enable <= accept && byte_pos[1];
            pixel_done <= accept && (byte_pos == 2'd3);
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            case (byte_pos)
                2'd0: row <= data_rx[ROW_BITS-1:0];
                2'd1: col <= data_rx[COL_BITS-1:0];
                default: begin
                    pixel_data <= data_rx;
                    // first colour byte goes to the high byte select
                    pixsel <= ~byte_pos[PIXSEL_BITS-1:0];
                end
            endcase
        end
    end

    assign pixel_address = {row, col, pixsel};

endmodule

`default_nettype wire

// ==== rtl/panel_ctrl_pkg.sv ====
// panel geometry, frame RAM address widths
// controller state and command opcode enums
`default_nettype none

package panel_ctrl_pkg;

    localparam int PIXEL_WIDTH = 64;
    localparam int PIXEL_HEIGHT = 32;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int BRIGHTNESS_LEVELS = 6;

    localparam int ROW_BITS = $clog2(PIXEL_HEIGHT);
    localparam int COL_BITS = $clog2(PIXEL_WIDTH);
    localparam int PIXSEL_BITS = $clog2(BYTES_PER_PIXEL);

    // byte address is {row, column, byte select}
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + PIXSEL_BITS;
    localparam int RAM_DEPTH = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_READ_BRIGHTNESS,
        STATE_BLANK_PANEL,
        STATE_READ_PIXEL
    } ctrl_state_e;

    // command bytes, ascii coded
    typedef enum logic [7:0] {
        OP_RED_ON          = 8'h52,
        OP_RED_OFF         = 8'h72,
        OP_GREEN_ON        = 8'h47,
        OP_GREEN_OFF       = 8'h67,
        OP_BLUE_ON         = 8'h42,
        OP_BLUE_OFF        = 8'h62,
        OP_BRIGHT_ALL_OFF  = 8'h30,
        OP_BRIGHT_ALL_ON   = 8'h39,
        OP_READ_BRIGHTNESS = 8'h54,
        OP_BLANK_PANEL     = 8'h5A,
        OP_READ_PIXEL      = 8'h50
    } cmd_opcode_e;

endpackage

`default_nettype wire

// ==== rtl/panel_ctrl_top.sv ====
// LED panel command controller top: dispatcher, blank and pixel engines,
// frame RAM write port mux
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top (
    input  logic                                       clk_in,
    input  logic                                       reset,
    input  logic [7:0]                                 data_rx,
    input  logic                                       data_ready_n,
    output logic [2:0]                                 rgb_enable,
    output logic [panel_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [panel_ctrl_pkg::ADDR_BITS-1:0]         ram_address,
    output logic [7:0]                                 ram_data_out,
    output logic                                       ram_write_enable,
    output logic                                       busy,
    output logic                                       ready_for_data
);
    import panel_ctrl_pkg::*;

    ctrl_state_e          cmd_state;
    logic [ADDR_BITS-1:0] blank_address;
    logic                 blank_write_enable;
    logic                 blank_done;
    logic [ADDR_BITS-1:0] pixel_address;
    logic [7:0]           pixel_data;
    logic                 pixel_write_enable;
    logic                 pixel_done;

    cmd_dispatch dispatch0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .blank_done        (blank_done),
        .pixel_done        (pixel_done),
        .cmd_state         (cmd_state),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    cmd_blankpanel blank0 (
        .clk_in             (clk_in),
        .reset              (reset),
        .cmd_state          (cmd_state),
        .blank_address      (blank_address),
        .blank_write_enable (blank_write_enable),
        .blank_done         (blank_done)
    );

    cmd_readpixel pixel0 (
        .clk_in             (clk_in),
        .reset              (reset),
        .cmd_state          (cmd_state),
        .data_rx            (data_rx),
        .data_ready_n       (data_ready_n),
        .pixel_address      (pixel_address),
        .pixel_data         (pixel_data),
        .pixel_write_enable (pixel_write_enable),
        .pixel_done         (pixel_done)
    );

    // RAM port follows the active engine, quiet otherwise
    always_comb begin
        ram_address = '0;
        ram_data_out = 8'h00;
        ram_write_enable = 1'b0;
        case (cmd_state)
            STATE_BLANK_PANEL: begin
                ram_address = blank_address;
                ram_write_enable = blank_write_enable;
            end
            STATE_READ_PIXEL: begin
                ram_address = pixel_address;
                ram_data_out = pixel_data;
                ram_write_enable = pixel_write_enable;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module panel_ctrl_tb -o sim
./obj_dir/sim +verilator+error+limit+100 | tee sim.log
if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

// ==== tb/panel_ctrl_checker.sv ====
// bound assertions on the controller top-level ports
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_checker (
    input logic clk_in,
    input logic reset,
    input logic ram_write_enable,
    input logic busy,
    input logic ready_for_data
);
    int assert_fails = 0;

    no_idle_write: assert property (@(posedge clk_in) disable iff (reset)
        ram_write_enable |-> busy)
        else begin
            $error("RAM write strobe while the controller is idle");
            assert_fails++;
        end

    ready_low_only_busy: assert property (@(posedge clk_in) disable iff (reset)
        !ready_for_data |-> busy)
        else begin
            $error("ready_for_data low while not busy");
            assert_fails++;
        end

    // state must come out of reset idle
    idle_after_reset: assert property (@(posedge clk_in) $fell(reset) |-> !busy)
        else begin
            $error("busy high right after reset release");
            assert_fails++;
        end

endmodule

bind panel_ctrl_top panel_ctrl_checker checker0 (
    .clk_in           (clk_in),
    .reset            (reset),
    .ram_write_enable (ram_write_enable),
    .busy             (busy),
    .ready_for_data   (ready_for_data)
);

`default_nettype wire

// ==== tb/panel_ctrl_monitor.sv ====
// reference model of the command rules, shadow frame RAM,
// per-test comparison and timeout counter
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_monitor (
    input  logic                                         clk_in,
    input  logic                                         reset,
    input  logic [7:0]                                   data_rx,
    input  logic                                         data_ready_n,
    input  logic [2:0]                                   rgb_enable,
    input  logic [panel_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    input  logic [panel_ctrl_pkg::ADDR_BITS-1:0]         ram_address,
    input  logic [7:0]                                   ram_data_out,
    input  logic                                         ram_write_enable,
    input  logic                                         busy,
    input  logic                                         ready_for_data,
    input  logic                                         test_end,
    input  int                                           test_id,
    input  int                                           cycle_limit,
    output logic                                         timed_out,
    output int                                           tests_run,
    output int                                           tests_failed
);
    import panel_ctrl_pkg::*;

    logic [7:0]                  shadow [RAM_DEPTH];
    logic [7:0]                  exp_mem [RAM_DEPTH];
    int                          wr_cnt [RAM_DEPTH];
    int                          exp_cnt [RAM_DEPTH];
    ctrl_state_e                 mstate;
    logic [2:0]                  exp_rgb;
    logic [BRIGHTNESS_LEVELS-1:0] exp_bright;
    logic [ROW_BITS-1:0]         row;
    logic [COL_BITS-1:0]         col;
    int                          blank_left;
    int                          pix_pos;
    int                          errs;
    int                          cycles;
    logic                        accept;

    task automatic report(input string msg);
        errs++;
        if (errs <= 8) begin
            $display("Error at %0t: %s", $time, msg);
        end
    endtask

    task automatic expect_write(input int addr, input logic [7:0] d);
        exp_mem[addr] = d;
        exp_cnt[addr]++;
    endtask

    task automatic model_byte(input logic [7:0] b);
        case (mstate)
            STATE_READ_BRIGHTNESS: begin
                exp_bright = b[BRIGHTNESS_LEVELS-1:0];
                mstate = STATE_IDLE;
            end
            STATE_READ_PIXEL: begin
                if (pix_pos == 0) begin
                    row = b[ROW_BITS-1:0];
                end else if (pix_pos == 1) begin
                    col = b[COL_BITS-1:0];
                end else begin
                    // first colour byte lands on byte select 1
                    expect_write(int'({row, col, (pix_pos == 2) ? 1'b1 : 1'b0}), b);
                end
                pix_pos++;
                if (pix_pos == 4) begin
                    mstate = STATE_IDLE;
                end
            end
            default: begin
                if (b == "R") exp_rgb[0] = 1'b1;
                else if (b == "r") exp_rgb[0] = 1'b0;
                else if (b == "G") exp_rgb[1] = 1'b1;
                else if (b == "g") exp_rgb[1] = 1'b0;
                else if (b == "B") exp_rgb[2] = 1'b1;
                else if (b == "b") exp_rgb[2] = 1'b0;
                else if (b == "0") exp_bright = '0;
                else if (b == "9") exp_bright = '1;
                else if (b >= "1" && b <= "6") begin
                    exp_bright[6 - int'(b - "0")] = ~exp_bright[6 - int'(b - "0")];
                end else if (b == "T") mstate = STATE_READ_BRIGHTNESS;
                else if (b == "P") begin
                    mstate = STATE_READ_PIXEL;
                    pix_pos = 0;
                end else if (b == "Z") begin
                    for (int a = 0; a < RAM_DEPTH; a++) begin
                        expect_write(a, 8'h00);
                    end
                    blank_left = RAM_DEPTH;
                end
            end
        endcase
    endtask

    // register values one cycle after each accepting edge
    task automatic compare_regs();
        if (rgb_enable !== exp_rgb)
            report($sformatf("rgb_enable is %b, expected %b", rgb_enable, exp_rgb));
        if (brightness_enable !== exp_bright)
            report($sformatf("brightness_enable is %b, expected %b",
                             brightness_enable, exp_bright));
    endtask

    task automatic finish_test();
        if (busy !== 1'b0)
            report("busy still high at end of test");
        for (int a = 0; a < RAM_DEPTH; a++) begin
            if (shadow[a] !== exp_mem[a] || wr_cnt[a] != exp_cnt[a])
                report($sformatf("address %0d holds %h after %0d writes, expected %h after %0d",
                                 a, shadow[a], wr_cnt[a], exp_mem[a], exp_cnt[a]));
            wr_cnt[a] = 0;
            exp_cnt[a] = 0;
        end
        tests_run++;
        if (errs == 0) begin
            $display("test %0d: passed", test_id);
        end else begin
            $display("test %0d: failed, %0d errors", test_id, errs);
            tests_failed++;
        end
        errs = 0;
    endtask

    initial begin
        for (int a = 0; a < RAM_DEPTH; a++) begin
            shadow[a] = 8'(a ^ (a >> 4));
            exp_mem[a] = shadow[a];
            wr_cnt[a] = 0;
            exp_cnt[a] = 0;
        end
        tests_run = 0;
        tests_failed = 0;
        errs = 0;
        cycles = 0;
        timed_out = 1'b0;
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            timed_out <= 1'b1;
        end
        if (reset) begin
            mstate = STATE_IDLE;
            exp_rgb = 3'b111;
            exp_bright = '1;
            blank_left = 0;
            pix_pos = 0;
        end else begin
            if (ram_write_enable) begin
                shadow[ram_address] = ram_data_out;
                wr_cnt[ram_address]++;
            end
            if (ready_for_data !== (blank_left == 0))
                report($sformatf("ready_for_data is %b with %0d blank cycles left",
                                 ready_for_data, blank_left));
            compare_regs();
            accept = !data_ready_n && (blank_left == 0);
            if (blank_left > 0) begin
                blank_left--;
            end
            if (accept) begin
                model_byte(data_rx);
            end
            if (test_end) begin
                finish_test();
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/panel_ctrl_tb.sv ====
// testbench top: clock, reset, stimulus table, DUT and monitor
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_tb;
    import panel_ctrl_pkg::*;

    localparam int NUM_ROWS = 26;

    logic                         clk_in;
    logic                         reset;
    logic [7:0]                   data_rx;
    logic                         data_ready_n;
    logic [2:0]                   rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [ADDR_BITS-1:0]         ram_address;
    logic [7:0]                   ram_data_out;
    logic                         ram_write_enable;
    logic                         busy;
    logic                         ready_for_data;
    logic                         test_end;
    logic                         timed_out;
    int                           test_id;
    int                           cycle_limit;
    int                           tests_run;
    int                           tests_failed;
    int                           seed;

    // byte, gap after it (-1 is random), test index, strobe even when not ready
    logic [7:0] tbl_byte [NUM_ROWS] = '{"r", "g", "B", "b", "G",
                                        "0", "3", "5", "9", "1",
                                        "T", 8'h6A, "x",
                                        "P", 8'd7, 8'd40, 8'hA5, 8'h3C,
                                        "Z", "R", "0", "P", 8'd3, 8'd10, 8'h11, 8'h22};
    int tbl_gap [NUM_ROWS] = '{2, -1, 2, -1, 2, 2, -1, 2, 2, 2, 1, 2, 2,
                               0, 1, 0, 1, 2, 0, 0, 1, 1, 0, 1, 0, 2};
    int tbl_test [NUM_ROWS] = '{1, 1, 1, 1, 1, 2, 2, 2, 2, 2, 3, 3, 3,
                                4, 4, 4, 4, 4, 5, 5, 5, 5, 5, 5, 5, 5};
    bit tbl_force [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                                 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0};

    panel_ctrl_top dut0 (.*);

    panel_ctrl_monitor monitor0 (.*);

    task automatic next_cycle();
        @(posedge clk_in);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b, input bit force_it);
        while (!force_it && !ready_for_data) begin
            next_cycle();
        end
        data_rx = b;
        data_ready_n = 1'b0;
        next_cycle();
        data_ready_n = 1'b1;
    endtask

    task automatic end_test();
        while (busy) begin
            next_cycle();
        end
        next_cycle();
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        if (timed_out) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        test_end = 1'b0;
        test_id = 0;
        seed = 84507;
        cycle_limit = 200 + 16 + 3 * NUM_ROWS + 5 * 5;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (tbl_gap[i] < 0) begin
                tbl_gap[i] = 1 + int'($unsigned($random(seed)) % 4);
            end
            cycle_limit += tbl_gap[i];
            if (tbl_byte[i] == "Z") begin
                cycle_limit += RAM_DEPTH;
            end
        end
        repeat (16) @(posedge clk_in);
        #2;
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            test_id = tbl_test[i];
            send_byte(tbl_byte[i], tbl_force[i]);
            repeat (tbl_gap[i]) next_cycle();
            if (i == NUM_ROWS - 1 || tbl_test[i + 1] != tbl_test[i]) begin
                end_test();
            end
        end
        $display("%0d tests run, %0d failed, %0d assertion failures",
                 tests_run, tests_failed, dut0.checker0.assert_fails);
        if (tests_failed == 0 && tests_run == 5 && dut0.checker0.assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
